// File: verilog.f
src/gb_pkg.sv
src/gb_memmap.sv
src/gb_iomap.sv
src/gb_div.sv
src/gb_hram.sv
src/gb_bootrom.sv
src/gb_mbc.sv
src/gb_bus_top.sv
testbench/gb_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module gb_tb -f verilog.f -o gb_tb_sim

out=$(./obj_dir/gb_tb_sim)
echo "$out"

if echo "$out" | grep -q "Test completed successfully"; then
	exit 0
fi
exit 1

// File: src/bootrom.hex
// Boot ROM image, 16 bytes per line starting at address 00.
5a 5b 58 59 5e 5f 5c 5d 52 53 50 51 56 57 54 55
4a 4b 48 49 4e 4f 4c 4d 42 43 40 41 46 47 44 45
7a 7b 78 79 7e 7f 7c 7d 72 73 70 71 76 77 74 75
6a 6b 68 69 6e 6f 6c 6d 62 63 60 61 66 67 64 65
1a 1b 18 19 1e 1f 1c 1d 12 13 10 11 16 17 14 15
0a 0b 08 09 0e 0f 0c 0d 02 03 00 01 06 07 04 05
3a 3b 38 39 3e 3f 3c 3d 32 33 30 31 36 37 34 35
2a 2b 28 29 2e 2f 2c 2d 22 23 20 21 26 27 24 25
da db d8 d9 de df dc dd d2 d3 d0 d1 d6 d7 d4 d5
ca cb c8 c9 ce cf cc cd c2 c3 c0 c1 c6 c7 c4 c5
fa fb f8 f9 fe ff fc fd f2 f3 f0 f1 f6 f7 f4 f5
ea eb e8 e9 ee ef ec ed e2 e3 e0 e1 e6 e7 e4 e5
9a 9b 98 99 9e 9f 9c 9d 92 93 90 91 96 97 94 95
8a 8b 88 89 8e 8f 8c 8d 82 83 80 81 86 87 84 85
ba bb b8 b9 be bf bc bd b2 b3 b0 b1 b6 b7 b4 b5
aa ab a8 a9 ae af ac ad a2 a3 a0 a1 a6 a7 a4 a5

// File: testbench/gb_tb.sv
module gb_tb import gb_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int test_cycles = 2 * 256 + 3 * hram_depth + 600 + 100; // Rough length of all tests.
	localparam int watchdog_cycles = 2 * test_cycles;

	logic gbclk, rst, emu_mbc;
	gb_bus_req_t cpu_bus;
	logic [7:0] rdata, ext_rdata, ext_wdata;
	logic [ext_adr_width-1:0] ext_adr;
	logic ext_drive, n_read, n_write, n_ram_cs, n_cart_cs, n_crom_cs, n_cram_cs;

	logic [7:0] boot_image [0:255];
	logic [31:0] rng_state = 32'h3e39_a9aa;
	int errors = 0;
	int checks = 0;

	gb_bus_top dut_i (.*);

	// External SRAM and cartridge answer only while selected.
	assign ext_rdata = (!n_read && !(n_ram_cs && n_cart_cs && n_crom_cs && n_cram_cs))
		? ext_value(ext_adr) : 8'hff;

	initial begin
		gbclk = 1'b0;
		forever #20 gbclk = ~gbclk;
	end

	function automatic logic [7:0] ext_value(input logic [20:0] a);
		return a[7:0] ^ a[20:13];
	endfunction

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic bus_read(input logic [15:0] adr, output logic [7:0] data);
		@(negedge gbclk);
		cpu_bus = {adr, 8'h00, 1'b1, 1'b0};
		#10;
		data = rdata;
	endtask

	// The write lands at the next rising edge.
	task automatic bus_write(input logic [15:0] adr, input logic [7:0] data);
		@(negedge gbclk);
		cpu_bus = {adr, data, 1'b0, 1'b1};
		#10;
	endtask

	task automatic bus_idle();
		@(negedge gbclk);
		cpu_bus = '0;
	endtask

	task automatic boot_overlay();
		logic [7:0] d;
		for (int i = 0; i < 256; i++) begin
			bus_read(16'(i), d);
			check("rdata", 32'(d), 32'(boot_image[i]));
		end
		bus_write(16'hff50, 8'h00); // Zero leaves the overlay in place.
		bus_read(16'h0042, d);
		check("rdata", 32'(d), 32'(boot_image[8'h42]));
		bus_write(16'hff50, 8'h01);
		for (int i = 0; i < 256; i++) begin
			bus_read(16'(i), d);
			check("rdata", 32'(d), 32'(ext_value(21'(i))));
		end
	endtask

	task automatic hram_access();
		logic [7:0] data [0:hram_depth-1];
		logic [7:0] d;
		for (int i = 0; i < hram_depth; i++) begin
			rng_state = xorshift(rng_state);
			data[i] = rng_state[7:0];
			bus_write(16'(16'hff80 + i), data[i]);
		end
		for (int i = 0; i < hram_depth; i++) begin
			bus_read(16'(16'hff80 + i), d);
			check("rdata", 32'(d), 32'(data[i]));
		end
		bus_read(16'hffff, d);
		check("rdata", 32'(d), 32'(open_bus));
		bus_read(16'hff10, d);
		check("rdata", 32'(d), 32'(open_bus));
		bus_read(16'h8000, d);
		check("rdata", 32'(d), 32'(open_bus));
	endtask

	task automatic mbc_banking();
		logic [7:0] banks [0:4];
		logic [4:0] exp_bank [0:4];
		logic [1:0] upper;
		logic [15:0] adr;
		logic [20:0] exp_adr;
		logic [7:0] d;
		banks = '{8'h00, 8'h20, 8'h05, 8'h1f, 8'h33};
		exp_bank = '{5'h01, 5'h01, 5'h05, 5'h1f, 5'h13}; // Bank 0 reads as bank 1.
		for (int i = 0; i < 5; i++) begin
			upper = 2'(i + 1);
			bus_write(16'h2000, banks[i]);
			check("n_crom_cs", 32'(n_crom_cs), 0);
			check("n_write", 32'(n_write), 1); // ROM writes stay on board.
			bus_write(16'h4000, {6'd0, upper});
			rng_state = xorshift(rng_state);
			adr = {2'b01, rng_state[13:0]};
			exp_adr = {upper, exp_bank[i], adr[13:0]};
			bus_read(adr, d);
			check("ext_adr", 32'(ext_adr), 32'(exp_adr));
			check("rdata", 32'(d), 32'(ext_value(exp_adr)));
			check("n_crom_cs", 32'(n_crom_cs), 0);
		end
		bus_read(16'ha000, d);
		check("n_cram_cs", 32'(n_cram_cs), 1);
		bus_write(16'h0000, 8'h0a);
		rng_state = xorshift(rng_state);
		adr = {3'b101, rng_state[12:0]};
		exp_adr = {6'd0, upper, adr[12:0]};
		bus_read(adr, d);
		check("n_cram_cs", 32'(n_cram_cs), 0);
		check("ext_adr", 32'(ext_adr), 32'(exp_adr));
		check("rdata", 32'(d), 32'(ext_value(exp_adr)));
		bus_write(16'h0000, 8'h00);
		bus_read(16'ha000, d);
		check("n_cram_cs", 32'(n_cram_cs), 1);
	endtask

	task automatic pass_through_mode();
		logic [7:0] d;
		logic [7:0] data;
		@(negedge gbclk) emu_mbc = 1'b0;
		bus_write(16'h2000, 8'h07); // Must not reach the bank register.
		bus_read(16'h4567, d);
		check("ext_adr", 32'(ext_adr), 32'h04567);
		check("n_cart_cs", 32'(n_cart_cs), 0);
		check("n_crom_cs", 32'(n_crom_cs), 1);
		check("rdata", 32'(d), 32'(ext_value(21'h04567)));
		bus_read(16'ha010, d);
		check("ext_adr", 32'(ext_adr), 32'h0a010);
		check("n_cart_cs", 32'(n_cart_cs), 0);
		rng_state = xorshift(rng_state);
		data = rng_state[7:0];
		bus_write(16'hc000, data);
		check("n_write", 32'(n_write), 0);
		check("n_ram_cs", 32'(n_ram_cs), 0);
		check("ext_drive", 32'(ext_drive), 1);
		check("ext_wdata", 32'(ext_wdata), 32'(data));
		@(negedge gbclk) emu_mbc = 1'b1;
		bus_read(16'h4000, d);
		// Bank registers still hold upper 1 and rom 13 from the MBC test.
		check("ext_adr", 32'(ext_adr), 32'({2'b01, 5'h13, 14'h0000}));
	endtask

	task automatic divider_count();
		logic [7:0] d;
		bus_write(16'hff04, 8'h5a);
		bus_idle();
		bus_read(16'hff04, d);
		check("rdata", 32'(d), 0);
		repeat (100) @(negedge gbclk);
		bus_read(16'hff04, d);
		check("rdata", 32'(d), 0);
		repeat (500) @(negedge gbclk);
		bus_read(16'hff04, d);
		checks++;
		if (d !== 8'h02 && d !== 8'h03) begin
			errors++;
			$display("error rdata: got %h, expected 02 or 03", d);
		end
	endtask

	task automatic reset_state();
		logic [7:0] d;
		@(negedge gbclk);
		rst = 1'b1;
		cpu_bus = {16'hc000, 8'h00, 1'b1, 1'b0};
		#10;
		check("n_ram_cs", 32'(n_ram_cs), 1);
		@(negedge gbclk);
		cpu_bus = {16'h4000, 8'h00, 1'b1, 1'b0};
		#10;
		check("n_crom_cs", 32'(n_crom_cs), 1);
		@(negedge gbclk);
		rst = 1'b0;
		cpu_bus = '0;
		#10;
		check("n_read", 32'(n_read), 1);
		check("n_write", 32'(n_write), 1);
		check("ext_drive", 32'(ext_drive), 0);
		check("n_ram_cs", 32'(n_ram_cs), 1);
		check("n_cart_cs", 32'(n_cart_cs), 1);
		check("n_crom_cs", 32'(n_crom_cs), 1);
		check("n_cram_cs", 32'(n_cram_cs), 1);
		bus_read(16'h0000, d);
		check("rdata", 32'(d), 32'(boot_image[0]));
		bus_read(16'h00ff, d);
		check("rdata", 32'(d), 32'(boot_image[255]));
	endtask

	initial begin
		rst = 1'b1;
		emu_mbc = 1'b1;
		cpu_bus = '0;
		$readmemh("src/bootrom.hex", boot_image);
		repeat (2) @(posedge gbclk);
		@(negedge gbclk) rst = 1'b0;
		boot_overlay();
		hram_access();
		mbc_banking();
		pass_through_mode();
		divider_count();
		reset_state();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge gbclk);
		$display("Timeout: tests still running after %0d cycles", watchdog_cycles);
		$display("%0d checks, %0d errors", checks, errors);
		$display("Test failed");
		$finish;
	end

endmodule

// File: src/gb_bus_top.sv
module gb_bus_top import gb_pkg::*; (
	input  logic                     gbclk,
	input  logic                     rst,
	input  logic                     emu_mbc,
	input  gb_bus_req_t              cpu_bus,
	output logic [7:0]               rdata,
	input  logic [7:0]               ext_rdata,
	output logic [ext_adr_width-1:0] ext_adr,
	output logic [7:0]               ext_wdata,
	output logic                     ext_drive,
	output logic                     n_read,
	output logic                     n_write,
	output logic                     n_ram_cs,
	output logic                     n_cart_cs,
	output logic                     n_crom_cs,
	output logic                     n_cram_cs
);

	gb_region_t region;
	gb_io_sel_t io_sel;

	logic       hidden;
	logic [7:0] div_rdata;
	logic [7:0] hram_rdata;
	logic [7:0] brom_rdata;
	logic       crom_sel;
	logic       cram_sel;
	logic       cart_sel;
	logic       ext_region;

	assign ext_region = region.wram || region.cart_rom || region.cart_ram;

	gb_memmap u_memmap (
		.adr            (cpu_bus.adr),
		.bootrom_hidden (hidden),
		.region         (region)
	);

	gb_iomap u_iomap (
		.enable (region.io),
		.adr    (cpu_bus.adr[7:0]),
		.io_sel (io_sel)
	);

	gb_div u_div (
		.gbclk (gbclk),
		.rst   (rst),
		.write (cpu_bus.write && io_sel.divider),
		.rdata (div_rdata)
	);

	gb_hram u_hram (
		.gbclk (gbclk),
		.adr   (cpu_bus.adr[6:0]),
		.wdata (cpu_bus.wdata),
		.write (cpu_bus.write && region.hram),
		.rdata (hram_rdata)
	);

	gb_bootrom u_bootrom (
		.gbclk     (gbclk),
		.rst       (rst),
		.adr       (cpu_bus.adr[7:0]),
		.wdata     (cpu_bus.wdata),
		.write_reg (cpu_bus.write && io_sel.bootrom_reg),
		.rdata     (brom_rdata),
		.hidden    (hidden)
	);

	gb_mbc u_mbc (
		.gbclk    (gbclk),
		.rst      (rst),
		.emu_mbc  (emu_mbc),
		.adr      (cpu_bus.adr),
		.wdata    (cpu_bus.wdata),
		.write    (cpu_bus.write && (region.cart_rom || region.cart_ram)),
		.region   (region),
		.ext_adr  (ext_adr),
		.crom_sel (crom_sel),
		.cram_sel (cram_sel),
		.cart_sel (cart_sel)
	);

	// VRAM, OAM and unused I/O fall through to the open bus value.
	always_comb begin
		if (region.hram)
			rdata = hram_rdata;
		else if (io_sel.divider)
			rdata = div_rdata;
		else if (region.bootrom)
			rdata = brom_rdata;
		else if (ext_region)
			rdata = ext_rdata;
		else
			rdata = open_bus;
	end

	assign ext_wdata = cpu_bus.wdata;
	assign ext_drive = cpu_bus.write && ext_region;
	assign n_read    = !(cpu_bus.read && ext_region);
	assign n_write   = crom_sel || !(cpu_bus.write && ext_region); // ROM never sees a write.

	assign n_ram_cs  = rst || !region.wram;
	assign n_cart_cs = rst || !cart_sel;
	assign n_crom_cs = rst || !crom_sel;
	assign n_cram_cs = rst || !cram_sel;

	// The CPU presents one access per cycle.
	assert property (@(posedge gbclk) disable iff (rst) !(cpu_bus.read && cpu_bus.write))
		else $error("gb_bus_top: read and write in the same cycle");

endmodule

// File: src/gb_mbc.sv
module gb_mbc import gb_pkg::*; (
	input  logic                     gbclk,
	input  logic                     rst,
	input  logic                     emu_mbc,
	input  logic [15:0]              adr,
	input  logic [7:0]               wdata,
	input  logic                     write,
	input  gb_region_t               region,
	output logic [ext_adr_width-1:0] ext_adr,
	output logic                     crom_sel,
	output logic                     cram_sel,
	output logic                     cart_sel
);

	logic       ram_enable;
	logic [4:0] rom_bank;
	logic [1:0] upper_bank;

	// Register writes land in the ROM half, decoded by adr[14:13].
	always_ff @(posedge gbclk) begin
		if (rst) begin
			ram_enable <= 1'b0;
			rom_bank   <= 5'd1;
			upper_bank <= 2'd0;
		end else if (emu_mbc && write && !adr[15]) begin
			case (adr[14:13])
				2'b00: ram_enable <= (wdata[3:0] == 4'ha);
				2'b01: rom_bank <= (wdata[4:0] == 5'd0) ? 5'd1 : wdata[4:0];
				2'b10: upper_bank <= wdata[1:0];
				default: ; // Mode select is not modelled.
			endcase
		end
	end

	always_comb begin
		ext_adr = {{(ext_adr_width-16){1'b0}}, adr};
		if (emu_mbc) begin
			if (region.cart_rom && adr[14])
				ext_adr = {upper_bank, rom_bank, adr[13:0]}; // Switchable bank.
			else if (region.cart_ram)
				ext_adr = {{(ext_adr_width-15){1'b0}}, upper_bank, adr[12:0]};
		end
	end

	always_comb begin
		if (emu_mbc) begin
			crom_sel = region.cart_rom;
			cram_sel = region.cart_ram && ram_enable;
			cart_sel = 1'b0;
		end else begin
			crom_sel = 1'b0;
			cram_sel = 1'b0;
			cart_sel = region.cart_rom || region.cart_ram; // Real cartridge decodes itself.
		end
	end

endmodule

// File: src/gb_bootrom.sv
module gb_bootrom (
	input  logic       gbclk,
	input  logic       rst,
	input  logic [7:0] adr,
	input  logic [7:0] wdata,
	input  logic       write_reg,
	output logic [7:0] rdata,
	output logic       hidden
);

	logic [7:0] rom [0:255];

	initial begin
		$readmemh("src/bootrom.hex", rom);
	end

	assign rdata = rom[adr];

	// Once hidden, the boot ROM stays out of the map until reset.
	always_ff @(posedge gbclk) begin
		if (rst)
			hidden <= 1'b0;
		else if (write_reg && wdata != 8'h00)
			hidden <= 1'b1;
	end

endmodule

// File: src/gb_hram.sv
module gb_hram import gb_pkg::*; (
	input  logic       gbclk,
	input  logic [6:0] adr,
	input  logic [7:0] wdata,
	input  logic       write,
	output logic [7:0] rdata
);

	logic [7:0] mem [0:hram_depth-1];

	always_ff @(posedge gbclk) begin
		if (write)
			mem[adr] <= wdata;
	end

	// Index 127 is the IE register and never reaches this array.
	assign rdata = mem[adr];

endmodule

// File: src/gb_div.sv
module gb_div (
	input  logic       gbclk,
	input  logic       rst,
	input  logic       write,
	output logic [7:0] rdata
);

	logic [15:0] count;

	// Any write clears the whole counter, not only the visible byte.
	always_ff @(posedge gbclk) begin
		if (rst || write)
			count <= '0;
		else
			count <= count + 16'd1;
	end

	assign rdata = count[15:8]; // DIV is the upper byte.

endmodule

// File: src/gb_iomap.sv
module gb_iomap import gb_pkg::*; (
	input  logic       enable,
	input  logic [7:0] adr,
	output gb_io_sel_t io_sel
);

	always_comb begin
		io_sel = '0;
		if (enable) begin
			case (adr) inside
				8'h00:           io_sel.joypad = 1'b1;
				[8'h01:8'h02]:   io_sel.serial = 1'b1;
				io_div:          io_sel.divider = 1'b1;
				[8'h05:8'h07]:   io_sel.timer = 1'b1; // TIMA, TMA, TAC.
				8'h0f:           io_sel.int_flag = 1'b1;
				[8'h10:8'h3f]:   io_sel.sound = 1'b1; // Sound registers and wave RAM.
				8'h46:           io_sel.dma = 1'b1; // Sits inside the PPU block.
				[8'h40:8'h4b]:   io_sel.ppu = 1'b1;
				io_brom:         io_sel.bootrom_reg = 1'b1;
				default:         io_sel = '0;
			endcase
		end
	end

endmodule

// File: src/gb_memmap.sv
module gb_memmap import gb_pkg::*; (
	input  logic [15:0] adr,
	input  logic        bootrom_hidden,
	output gb_region_t  region
);

	always_comb begin
		region = '0;
		if (adr < adr_vram_base) begin
			if (!bootrom_hidden && adr[15:8] == 8'h00)
				region.bootrom = 1'b1; // Overlay on the first 256 bytes.
			else
				region.cart_rom = 1'b1;
		end else if (adr < adr_cram_base) begin
			region.vram = 1'b1;
		end else if (adr < adr_wram_base) begin
			region.cart_ram = 1'b1;
		end else if (adr < adr_oam_base) begin
			region.wram = 1'b1; // Includes echo RAM E000-FDFF.
		end else if (adr < adr_oam_base + 16'h00a0) begin
			region.oam = 1'b1;
		end else if (adr < adr_io_base) begin
			region = '0; // FEA0-FEFF is unusable.
		end else if (adr < adr_hram_base) begin
			region.io = 1'b1;
		end else if (adr < adr_ie) begin
			region.hram = 1'b1;
		end else begin
			region.ie = 1'b1;
		end
	end

endmodule

// File: src/gb_pkg.sv
package gb_pkg;

	// Region bases of the CPU memory map.
	localparam logic [15:0] adr_vram_base = 16'h8000;
	localparam logic [15:0] adr_cram_base = 16'ha000;
	localparam logic [15:0] adr_wram_base = 16'hc000;
	localparam logic [15:0] adr_oam_base  = 16'hfe00;
	localparam logic [15:0] adr_io_base   = 16'hff00;
	localparam logic [15:0] adr_hram_base = 16'hff80;
	localparam logic [15:0] adr_ie        = 16'hffff;

	localparam logic [7:0] io_div  = 8'h04; // Offsets inside the FF00 page.
	localparam logic [7:0] io_brom = 8'h50;

	localparam int ext_adr_width = 21;
	localparam int hram_depth    = 127;
	localparam logic [7:0] open_bus = 8'hff;

	typedef struct packed {
		logic [15:0] adr;
		logic [7:0]  wdata;
		logic        read;
		logic        write;
	} gb_bus_req_t;

	typedef struct packed {
		logic bootrom;
		logic cart_rom;
		logic vram;
		logic cart_ram;
		logic wram;
		logic oam;
		logic io;
		logic hram;
		logic ie;
	} gb_region_t;

	typedef struct packed {
		logic       joypad;
		logic       serial;
		logic       divider;
		logic       timer;
		logic       int_flag;
		logic       sound;
		logic       ppu;
		logic       dma;
		logic       bootrom_reg;
		logic [1:0] spare;
	} gb_io_sel_t;

endpackage
